// File: dv/matrix_mac_sva.sv
`timescale 1ns/1ns

module matrix_mac_sva
(
  input logic dca_port_11,
  input logic dca_port_17,
  input logic i_busy,
  input logic i_step_req,
  input logic i_done
);

  // Done is a single-cycle pulse
  a_done_pulse: assert property (@(posedge dca_port_11) disable iff (!dca_port_17)
                                 i_done |=> !i_done)
    else $error("o_done high for two consecutive cycles");

  a_req_busy: assert property (@(posedge dca_port_11) disable iff (!dca_port_17)
                               i_step_req |-> i_busy)
    else $error("o_step_req high while not busy");

  a_done_busy: assert property (@(posedge dca_port_11) disable iff (!dca_port_17)
                                i_done |-> i_busy)
    else $error("o_done high while not busy");

  a_reset_idle: assert property (@(posedge dca_port_11) !dca_port_17 |-> !i_busy)
    else $error("o_busy high during reset");

endmodule

bind matrix_mac_top matrix_mac_sva matrix_mac_sva_i
(
  .dca_port_11 (dca_port_11),
  .dca_port_17 (dca_port_17),
  .i_busy      (o_busy),
  .i_step_req  (o_step_req),
  .i_done      (o_done)
);

// File: dv/tb_matrix_mac.sv
`timescale 1ns/1ns

module tb_matrix_mac;

  localparam int DIM          = 4;
  localparam int EW           = 16;
  localparam int NE           = DIM * DIM;
  localparam int MAT_W        = NE * EW;
  localparam int MAX_STEPS    = 15;
  localparam int CLK_PERIOD   = 8;
  localparam int RST_CYCLES   = 10;
  localparam int NUM_RUNS     = 8;
  // Issue, pipeline drain and gaps between runs
  localparam int RUN_OVERHEAD = 12;
  localparam int DONE_TIMEOUT = MAX_STEPS + RUN_OVERHEAD;
  localparam int WATCHDOG_NS  =
    2 * CLK_PERIOD * (RST_CYCLES + NUM_RUNS * (MAX_STEPS + RUN_OVERHEAD));

  logic                       dca_port_11;
  logic                       dca_port_17;
  logic                       i_start;
  logic                       i_clear;
  mac_pkg::op_e               i_opcode;
  logic                       i_init_acc;
  logic [DIM-1:0]             i_row_mask;
  logic [DIM-1:0]             i_col_mask;
  logic [mac_pkg::STEP_W-1:0] i_steps;
  logic [MAT_W-1:0]           i_lhs;
  logic [MAT_W-1:0]           i_rhs;
  logic                       o_busy;
  logic                       o_step_req;
  logic                       o_done;
  logic [MAT_W-1:0]           o_result;

  // Reference accumulator and the operand pairs of the current run
  logic [MAT_W-1:0] model_acc;
  logic [MAT_W-1:0] lhs_pairs [MAX_STEPS];
  logic [MAT_W-1:0] rhs_pairs [MAX_STEPS];
  logic [15:0]      lfsr;

  matrix_mac_top #(.MATRIX_DIM(DIM), .ELEM_W(EW)) matrix_mac_top_i
  (
    .dca_port_11 (dca_port_11),
    .dca_port_17 (dca_port_17),
    .i_start     (i_start),
    .i_clear     (i_clear),
    .i_opcode    (i_opcode),
    .i_init_acc  (i_init_acc),
    .i_row_mask  (i_row_mask),
    .i_col_mask  (i_col_mask),
    .i_steps     (i_steps),
    .i_lhs       (i_lhs),
    .i_rhs       (i_rhs),
    .o_busy      (o_busy),
    .o_step_req  (o_step_req),
    .o_done      (o_done),
    .o_result    (o_result)
  );

  initial
  begin
    dca_port_11 = 1'b0;
    forever #(CLK_PERIOD/2) dca_port_11 = ~dca_port_11;
  end

  initial
  begin
    #(WATCHDOG_NS);
    report_timeout("watchdog expired before the tests finished");
  end

  // ****************************************
  // Helpers
  // ****************************************
  task automatic check_value(input string what, input logic [MAT_W-1:0] got,
                             input logic [MAT_W-1:0] exp);
    if (got !== exp)
    begin
      $display("[FAIL] %0t ns %s: got %h, expected %h", $time, what, got, exp);
      $display("** FAIL **");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout at %0t ns: %s", $time, what);
    $display("** FAIL **");
    $fatal(1, "Run ended by timeout");
  endtask

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw_elem(output logic [EW-1:0] val);
    val = '0;
    for (int i = 0; i < EW; i++)
    begin
      lfsr = lfsr_next(lfsr);
      val  = {val[EW-2:0], lfsr[15]};
    end
  endtask

  task automatic fill_pairs(input int n);
    logic [EW-1:0] val;
    for (int k = 0; k < n; k++)
    begin
      for (int i = 0; i < NE; i++)
      begin
        draw_elem(val);
        lhs_pairs[k][i*EW +: EW] = val;
        draw_elem(val);
        rhs_pairs[k][i*EW +: EW] = val;
      end
    end
  endtask

  task automatic apply_model(input mac_pkg::op_e op, input logic init,
                             input logic [DIM-1:0] row, input logic [DIM-1:0] col,
                             input int n_steps);
    logic [EW-1:0] a;
    logic [EW-1:0] b;
    logic [EW-1:0] cur;
    int            idx;
    for (int k = 0; k < n_steps; k++)
    begin
      for (int r = 0; r < DIM; r++)
      begin
        for (int c = 0; c < DIM; c++)
        begin
          idx = r*DIM + c;
          cur = model_acc[idx*EW +: EW];
          a   = lhs_pairs[k][idx*EW +: EW];
          b   = rhs_pairs[k][idx*EW +: EW];
          case (op)
            mac_pkg::OP_ADD:   cur = a + b;
            mac_pkg::OP_SUB:   cur = a - b;
            mac_pkg::OP_EWMUL: cur = a * b;
            default:
            begin
              // Column 0 of lhs times row 0 of rhs
              a   = lhs_pairs[k][(r*DIM)*EW +: EW];
              b   = rhs_pairs[k][c*EW +: EW];
              cur = (k == 0 && init) ? a * b : cur + a * b;
            end
          endcase
          if (row[r] && col[c])
            model_acc[idx*EW +: EW] = cur;
        end
      end
    end
  endtask

  // Runs one instruction, feeding a pair per request, then checks the bank
  task automatic run_instr(input mac_pkg::op_e op, input logic init,
                           input logic [DIM-1:0] row, input logic [DIM-1:0] col,
                           input logic [mac_pkg::STEP_W-1:0] steps, input bit poke_start);
    int req_cnt;
    int wait_cnt;
    int exp_steps;
    exp_steps = (op == mac_pkg::OP_OUTER && steps != 0) ? int'(steps) : 1;
    @(negedge dca_port_11);
    i_start    = 1'b1;
    i_opcode   = op;
    i_init_acc = init;
    i_row_mask = row;
    i_col_mask = col;
    i_steps    = steps;
    @(negedge dca_port_11);
    i_start  = 1'b0;
    req_cnt  = 0;
    wait_cnt = 0;
    while (!o_done)
    begin
      if (o_step_req)
      begin
        if (req_cnt < MAX_STEPS)
        begin
          i_lhs = lhs_pairs[req_cnt];
          i_rhs = rhs_pairs[req_cnt];
        end
        req_cnt++;
        // Another instruction offered while busy must be ignored
        if (poke_start)
        begin
          i_start    = 1'b1;
          i_opcode   = mac_pkg::OP_SUB;
          i_row_mask = '0;
          i_steps    = 4'd9;
        end
      end
      else
        i_start = 1'b0;
      if (wait_cnt == DONE_TIMEOUT)
        report_timeout("o_done not seen within the run bound");
      wait_cnt++;
      @(negedge dca_port_11);
    end
    apply_model(op, init, row, col, exp_steps);
    check_value("step request count", req_cnt, exp_steps);
    check_value("o_busy in done cycle", o_busy, 1'b1);
    check_value("o_result", o_result, model_acc);
    @(negedge dca_port_11);
    check_value("o_busy after done", o_busy, 1'b0);
    check_value("o_done after done", o_done, 1'b0);
  endtask

  // ****************************************
  // Directed tests
  // ****************************************
  task automatic test_reset_state();
    check_value("o_busy after reset", o_busy, 1'b0);
    check_value("o_step_req after reset", o_step_req, 1'b0);
    check_value("o_done after reset", o_done, 1'b0);
    check_value("o_result after reset", o_result, '0);
  endtask

  task automatic test_add_sub();
    fill_pairs(1);
    run_instr(mac_pkg::OP_ADD, 1'b0, 4'hf, 4'hf, 4'd5, 1'b0);
    fill_pairs(1);
    run_instr(mac_pkg::OP_SUB, 1'b0, 4'b0101, 4'b0110, 4'd0, 1'b0);
  endtask

  task automatic test_ewmul();
    fill_pairs(1);
    // Products that overflow 16 bits
    lhs_pairs[0][0*EW +: EW] = 16'h7fff;
    rhs_pairs[0][0*EW +: EW] = 16'h0003;
    lhs_pairs[0][1*EW +: EW] = 16'h8000;
    rhs_pairs[0][1*EW +: EW] = 16'hffff;
    run_instr(mac_pkg::OP_EWMUL, 1'b0, 4'hf, 4'hf, 4'd0, 1'b0);
  endtask

  task automatic test_outer();
    fill_pairs(4);
    run_instr(mac_pkg::OP_OUTER, 1'b1, 4'hf, 4'hf, 4'd4, 1'b0);
    fill_pairs(3);
    run_instr(mac_pkg::OP_OUTER, 1'b0, 4'hf, 4'hf, 4'd3, 1'b0);
  endtask

  task automatic test_start_while_busy();
    fill_pairs(3);
    run_instr(mac_pkg::OP_OUTER, 1'b1, 4'b1011, 4'b1101, 4'd3, 1'b1);
  endtask

  task automatic test_abort();
    fill_pairs(8);
    @(negedge dca_port_11);
    i_start    = 1'b1;
    i_opcode   = mac_pkg::OP_OUTER;
    i_init_acc = 1'b1;
    i_row_mask = 4'hf;
    i_col_mask = 4'hf;
    i_steps    = 4'd8;
    @(negedge dca_port_11);
    i_start = 1'b0;
    check_value("o_step_req before abort", o_step_req, 1'b1);
    i_lhs = lhs_pairs[0];
    i_rhs = rhs_pairs[0];
    @(negedge dca_port_11);
    i_lhs = lhs_pairs[1];
    i_rhs = rhs_pairs[1];
    @(negedge dca_port_11);
    i_clear = 1'b1;
    @(negedge dca_port_11);
    i_clear = 1'b0;
    check_value("o_busy after abort", o_busy, 1'b0);
    check_value("o_step_req after abort", o_step_req, 1'b0);
    check_value("o_done after abort", o_done, 1'b0);
    repeat (4)
    begin
      @(negedge dca_port_11);
      check_value("o_busy idle after abort", o_busy, 1'b0);
      check_value("o_done idle after abort", o_done, 1'b0);
    end
    // Full masks overwrite whatever the aborted run left behind
    fill_pairs(1);
    run_instr(mac_pkg::OP_ADD, 1'b0, 4'hf, 4'hf, 4'd0, 1'b0);
  endtask

  initial
  begin
    dca_port_17 = 1'b0;
    i_start     = 1'b0;
    i_clear     = 1'b0;
    i_opcode    = mac_pkg::OP_ADD;
    i_init_acc  = 1'b0;
    i_row_mask  = '0;
    i_col_mask  = '0;
    i_steps     = '0;
    i_lhs       = '0;
    i_rhs       = '0;
    model_acc   = '0;
    lfsr        = 16'd6301;
    repeat (RST_CYCLES) @(posedge dca_port_11);
    @(negedge dca_port_11);
    dca_port_17 = 1'b1;
    test_reset_state();
    test_add_sub();
    test_ewmul();
    test_outer();
    test_start_while_busy();
    test_abort();
    $display("** PASS **");
    $finish;
  end

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_matrix_mac \
  -f sim.f -o tb_matrix_mac
./obj_dir/tb_matrix_mac

// File: sim.f
verilog/mac_pkg.sv
verilog/mac_inst_if.sv
verilog/mac_wb_if.sv
verilog/mac_inst_reg.sv
verilog/mac_seq.sv
verilog/mac_lane.sv
verilog/mac_datapath.sv
verilog/mac_acc.sv
verilog/matrix_mac_top.sv
dv/matrix_mac_sva.sv
dv/tb_matrix_mac.sv

// File: verilog/mac_acc.sv
`timescale 1ns/1ns

module mac_acc
#(
  parameter int MATRIX_DIM = 4,
  parameter int ELEM_W     = 16
)
(
  input  logic                                    dca_port_11,
  input  logic                                    dca_port_17,
  mac_inst_if.acc                                 inst,
  mac_wb_if.acc                                   wb,
  output logic [MATRIX_DIM*MATRIX_DIM*ELEM_W-1:0] o_result
);

  localparam int NUM_ELEM = MATRIX_DIM * MATRIX_DIM;

  logic [NUM_ELEM-1:0][ELEM_W-1:0] bank;
  logic                            accumulate;

  // Outer products add onto the bank unless this is an init first step
  assign accumulate = wb.wb_is_mul && (inst.opcode == mac_pkg::OP_OUTER) &&
                      !(wb.wb_first && inst.init_acc);

  always_ff @(posedge dca_port_11 or negedge dca_port_17)
  begin
    if (!dca_port_17)
      bank <= '0;
    else if (wb.wb_valid)
    begin
      for (int i = 0; i < NUM_ELEM; i++)
      begin
        if (inst.elem_en[i])
        begin
          if (accumulate)
            bank[i] <= bank[i] + wb.wb_data[i*ELEM_W +: ELEM_W];
          else
            bank[i] <= wb.wb_data[i*ELEM_W +: ELEM_W];
        end
      end
    end
  end

  assign o_result = bank;

endmodule

// File: verilog/mac_datapath.sv
`timescale 1ns/1ns

module mac_datapath
#(
  parameter int MATRIX_DIM = 4,
  parameter int ELEM_W     = 16
)
(
  input  logic                                    dca_port_11,
  input  logic                                    dca_port_17,
  input  logic [MATRIX_DIM*MATRIX_DIM*ELEM_W-1:0] i_lhs,
  input  logic [MATRIX_DIM*MATRIX_DIM*ELEM_W-1:0] i_rhs,
  mac_inst_if.dp                                  inst,
  mac_wb_if.dp                                    wb
);

  localparam int NUM_ELEM = MATRIX_DIM * MATRIX_DIM;

  logic                       is_outer;
  logic                       is_sub;
  logic [NUM_ELEM*ELEM_W-1:0] sum_flat;
  logic [NUM_ELEM*ELEM_W-1:0] prod_flat;

  assign is_outer = (inst.opcode == mac_pkg::OP_OUTER);
  assign is_sub   = (inst.opcode == mac_pkg::OP_SUB);

  for (genvar r = 0; r < MATRIX_DIM; r++)
  begin : g_row
    for (genvar c = 0; c < MATRIX_DIM; c++)
    begin : g_col
      localparam int IDX = r*MATRIX_DIM + c;
      logic [ELEM_W-1:0] op_a;
      logic [ELEM_W-1:0] op_b;

      // Outer product takes lhs (r,0) and rhs (0,c)
      assign op_a = is_outer ? i_lhs[(r*MATRIX_DIM)*ELEM_W +: ELEM_W] : i_lhs[IDX*ELEM_W +: ELEM_W];
      assign op_b = is_outer ? i_rhs[c*ELEM_W +: ELEM_W] : i_rhs[IDX*ELEM_W +: ELEM_W];

      mac_lane #(.ELEM_W(ELEM_W)) mac_lane_i
      (
        .dca_port_11 (dca_port_11),
        .dca_port_17 (dca_port_17),
        .i_sub       (is_sub),
        .i_a         (op_a),
        .i_b         (op_b),
        .o_sum       (sum_flat[IDX*ELEM_W +: ELEM_W]),
        .o_prod      (prod_flat[IDX*ELEM_W +: ELEM_W])
      );
    end
  end

  assign wb.wb_data = wb.wb_is_mul ? prod_flat : sum_flat;

endmodule

// File: verilog/mac_inst_if.sv
`timescale 1ns/1ns

interface mac_inst_if
#(
  parameter int MATRIX_DIM = 4
);

  mac_pkg::op_e                     opcode;
  logic                             init_acc;
  logic [mac_pkg::STEP_W-1:0]       steps;
  // One write enable per element, row mask AND column mask
  logic [MATRIX_DIM*MATRIX_DIM-1:0] elem_en;

  modport drv (output opcode, init_acc, steps, elem_en);
  modport seq (input opcode, steps);
  modport dp  (input opcode);
  modport acc (input opcode, init_acc, elem_en);

endinterface

// File: verilog/mac_inst_reg.sv
`timescale 1ns/1ns

module mac_inst_reg
#(
  parameter int MATRIX_DIM = 4
)
(
  input  logic                       dca_port_11,
  input  logic                       dca_port_17,
  input  logic                       i_start,
  input  logic                       i_idle,
  input  mac_pkg::op_e               i_opcode,
  input  logic                       i_init_acc,
  input  logic [MATRIX_DIM-1:0]      i_row_mask,
  input  logic [MATRIX_DIM-1:0]      i_col_mask,
  input  logic [mac_pkg::STEP_W-1:0] i_steps,
  mac_inst_if.drv                    inst
);

  localparam int NUM_ELEM = MATRIX_DIM * MATRIX_DIM;

  logic [NUM_ELEM-1:0]        elem_en_nxt;
  logic [mac_pkg::STEP_W-1:0] steps_nxt;

  always_comb
  begin
    for (int r = 0; r < MATRIX_DIM; r++)
    begin
      for (int c = 0; c < MATRIX_DIM; c++)
      begin
        elem_en_nxt[r*MATRIX_DIM + c] = i_row_mask[r] & i_col_mask[c];
      end
    end
  end

  // Element-wise ops run one step, a zero count also means one
  always_comb
  begin
    steps_nxt = i_steps;
    if ((i_opcode != mac_pkg::OP_OUTER) || (i_steps == '0))
      steps_nxt = 'd1;
  end

  always_ff @(posedge dca_port_11 or negedge dca_port_17)
  begin
    if (!dca_port_17)
    begin
      inst.opcode   <= mac_pkg::OP_ADD;
      inst.init_acc <= 1'b0;
      inst.steps    <= 'd1;
      inst.elem_en  <= '0;
    end
    else if (i_start && i_idle)
    begin
      inst.opcode   <= i_opcode;
      inst.init_acc <= i_init_acc;
      inst.steps    <= steps_nxt;
      inst.elem_en  <= elem_en_nxt;
    end
  end

endmodule

// File: verilog/mac_lane.sv
`timescale 1ns/1ns

module mac_lane
#(
  parameter int ELEM_W = 16
)
(
  input  logic              dca_port_11,
  input  logic              dca_port_17,
  input  logic              i_sub,
  input  logic [ELEM_W-1:0] i_a,
  input  logic [ELEM_W-1:0] i_b,
  output logic [ELEM_W-1:0] o_sum,
  output logic [ELEM_W-1:0] o_prod
);

  logic [ELEM_W-1:0] sum_pipe [mac_pkg::ADD_LAT];
  logic [ELEM_W-1:0] prod_pipe [mac_pkg::MUL_LAT];

  // Add/subtract path
  always_ff @(posedge dca_port_11 or negedge dca_port_17)
  begin
    if (!dca_port_17)
    begin
      for (int i = 0; i < mac_pkg::ADD_LAT; i++)
        sum_pipe[i] <= '0;
    end
    else
    begin
      sum_pipe[0] <= i_sub ? (i_a - i_b) : (i_a + i_b);
      for (int i = 1; i < mac_pkg::ADD_LAT; i++)
        sum_pipe[i] <= sum_pipe[i-1];
    end
  end

  // Multiply path, low ELEM_W bits only so it wraps for signed values too
  always_ff @(posedge dca_port_11 or negedge dca_port_17)
  begin
    if (!dca_port_17)
    begin
      for (int i = 0; i < mac_pkg::MUL_LAT; i++)
        prod_pipe[i] <= '0;
    end
    else
    begin
      prod_pipe[0] <= i_a * i_b;
      for (int i = 1; i < mac_pkg::MUL_LAT; i++)
        prod_pipe[i] <= prod_pipe[i-1];
    end
  end

  assign o_sum  = sum_pipe[mac_pkg::ADD_LAT-1];
  assign o_prod = prod_pipe[mac_pkg::MUL_LAT-1];

endmodule

// File: verilog/mac_pkg.sv
package mac_pkg;

  // ****************************************
  // Operation codes
  // ****************************************
  typedef enum logic [1:0] {
    OP_ADD   = 2'd0,
    OP_SUB   = 2'd1,
    OP_EWMUL = 2'd2,
    OP_OUTER = 2'd3
  } op_e;

  // Step count width, up to 15 outer-product steps
  localparam int STEP_W = 4;

  // Result latencies in cycles, counted from the operand sample edge
  localparam int ADD_LAT = 1;
  localparam int MUL_LAT = 2;

endpackage

// File: verilog/mac_seq.sv
`timescale 1ns/1ns

module mac_seq
(
  input  logic    dca_port_11,
  input  logic    dca_port_17,
  input  logic    i_start,
  input  logic    i_clear,
  mac_inst_if.seq inst,
  mac_wb_if.seq   wb,
  output logic    o_idle,
  output logic    o_busy,
  output logic    o_step_req,
  output logic    o_done
);

  typedef enum logic {ST_IDLE, ST_RUN} state_e;

  state_e                      state;
  logic [mac_pkg::STEP_W-1:0]  step_cnt;
  logic [mac_pkg::STEP_W-1:0]  step_cnt_nxt;
  logic [mac_pkg::MUL_LAT-1:0] tag_valid;
  logic [mac_pkg::MUL_LAT-1:0] tag_first;
  logic                        is_mul;
  logic                        tags_pending;
  logic                        last_wb;
  int                          tap;

  assign is_mul = (inst.opcode == mac_pkg::OP_EWMUL) || (inst.opcode == mac_pkg::OP_OUTER);

  // Tap of the tag pipe that lines up with the lane result
  always_comb
  begin
    tap          = is_mul ? mac_pkg::MUL_LAT - 1 : mac_pkg::ADD_LAT - 1;
    tags_pending = 1'b0;
    for (int i = 0; i < mac_pkg::MUL_LAT; i++)
    begin
      if (i < tap)
        tags_pending = tags_pending | tag_valid[i];
    end
  end

  assign wb.wb_valid  = tag_valid[tap];
  assign wb.wb_first  = tag_first[tap];
  assign wb.wb_is_mul = is_mul;

  // Final writeback: nothing issued or in flight behind it
  assign last_wb      = wb.wb_valid && !o_step_req && !tags_pending;
  assign step_cnt_nxt = step_cnt + 1'b1;

  assign o_idle = (state == ST_IDLE);
  assign o_busy = (state == ST_RUN);

  // ****************************************
  // Control FSM
  // ****************************************
  always_ff @(posedge dca_port_11 or negedge dca_port_17)
  begin
    if (!dca_port_17)
    begin
      state      <= ST_IDLE;
      step_cnt   <= '0;
      o_step_req <= 1'b0;
      o_done     <= 1'b0;
    end
    else if (i_clear)
    begin
      state      <= ST_IDLE;
      o_step_req <= 1'b0;
      o_done     <= 1'b0;
    end
    else
    begin
      case (state)
        ST_IDLE:
          if (i_start)
          begin
            state      <= ST_RUN;
            step_cnt   <= '0;
            o_step_req <= 1'b1;
          end
        ST_RUN:
        begin
          if (o_step_req)
          begin
            step_cnt <= step_cnt_nxt;
            if (step_cnt_nxt == inst.steps)
              o_step_req <= 1'b0;
          end
          o_done <= last_wb;
          if (o_done)
            state <= ST_IDLE;
        end
        default:
          state <= ST_IDLE;
      endcase
    end
  end

  // One tag per sampled pair, abort drops whatever is in flight
  always_ff @(posedge dca_port_11 or negedge dca_port_17)
  begin
    if (!dca_port_17)
    begin
      tag_valid <= '0;
      tag_first <= '0;
    end
    else if (i_clear)
    begin
      tag_valid <= '0;
      tag_first <= '0;
    end
    else
    begin
      tag_valid <= {tag_valid[mac_pkg::MUL_LAT-2:0], o_step_req};
      tag_first <= {tag_first[mac_pkg::MUL_LAT-2:0], o_step_req && (step_cnt == '0)};
    end
  end

endmodule

// File: verilog/mac_wb_if.sv
`timescale 1ns/1ns

interface mac_wb_if
#(
  parameter int MATRIX_DIM = 4,
  parameter int ELEM_W     = 16
);

  logic                                    wb_valid;
  logic                                    wb_first;
  logic                                    wb_is_mul;
  logic [MATRIX_DIM*MATRIX_DIM*ELEM_W-1:0] wb_data;

  modport seq (output wb_valid, wb_first, wb_is_mul);
  modport dp  (input wb_is_mul, output wb_data);
  modport acc (input wb_valid, wb_first, wb_is_mul, wb_data);

endinterface

// File: verilog/matrix_mac_top.sv
`timescale 1ns/1ns

module matrix_mac_top
#(
  parameter int MATRIX_DIM = 4,
  parameter int ELEM_W     = 16
)
(
  input  logic                                    dca_port_11,
  input  logic                                    dca_port_17,
  input  logic                                    i_start,
  input  logic                                    i_clear,
  input  mac_pkg::op_e                            i_opcode,
  input  logic                                    i_init_acc,
  input  logic [MATRIX_DIM-1:0]                   i_row_mask,
  input  logic [MATRIX_DIM-1:0]                   i_col_mask,
  input  logic [mac_pkg::STEP_W-1:0]              i_steps,
  input  logic [MATRIX_DIM*MATRIX_DIM*ELEM_W-1:0] i_lhs,
  input  logic [MATRIX_DIM*MATRIX_DIM*ELEM_W-1:0] i_rhs,
  output logic                                    o_busy,
  output logic                                    o_step_req,
  output logic                                    o_done,
  output logic [MATRIX_DIM*MATRIX_DIM*ELEM_W-1:0] o_result
);

  logic seq_idle;

  mac_inst_if #(.MATRIX_DIM(MATRIX_DIM)) inst_bus ();
  mac_wb_if #(.MATRIX_DIM(MATRIX_DIM), .ELEM_W(ELEM_W)) wb_bus ();

  mac_inst_reg #(.MATRIX_DIM(MATRIX_DIM)) mac_inst_reg_i
  (
    .dca_port_11 (dca_port_11),
    .dca_port_17 (dca_port_17),
    .i_start     (i_start),
    .i_idle      (seq_idle),
    .i_opcode    (i_opcode),
    .i_init_acc  (i_init_acc),
    .i_row_mask  (i_row_mask),
    .i_col_mask  (i_col_mask),
    .i_steps     (i_steps),
    .inst        (inst_bus.drv)
  );

  mac_seq mac_seq_i
  (
    .dca_port_11 (dca_port_11),
    .dca_port_17 (dca_port_17),
    .i_start     (i_start),
    .i_clear     (i_clear),
    .inst        (inst_bus.seq),
    .wb          (wb_bus.seq),
    .o_idle      (seq_idle),
    .o_busy      (o_busy),
    .o_step_req  (o_step_req),
    .o_done      (o_done)
  );

  mac_datapath #(.MATRIX_DIM(MATRIX_DIM), .ELEM_W(ELEM_W)) mac_datapath_i
  (
    .dca_port_11 (dca_port_11),
    .dca_port_17 (dca_port_17),
    .i_lhs       (i_lhs),
    .i_rhs       (i_rhs),
    .inst        (inst_bus.dp),
    .wb          (wb_bus.dp)
  );

  mac_acc #(.MATRIX_DIM(MATRIX_DIM), .ELEM_W(ELEM_W)) mac_acc_i
  (
    .dca_port_11 (dca_port_11),
    .dca_port_17 (dca_port_17),
    .inst        (inst_bus.acc),
    .wb          (wb_bus.acc),
    .o_result    (o_result)
  );

endmodule
